// File: include/rtc_cfg.svh
`ifndef RTC_CFG_SVH
`define RTC_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus cycle timing, offsets inside the 32-clock cycle
////////////////////////////////////////////////////////////////////////////
`define RTC_CYCLE_LEN      32
`define RTC_CS1_LO         2     // Address phase select and write
`define RTC_CS1_HI         9
`define RTC_AD_LO          1     // Address/data low, address driven up to AD_HI-1
`define RTC_AD_HI          11
`define RTC_CS2_LO         20    // Data strobe
`define RTC_CS2_HI         27

////////////////////////////////////////////////////////////////////////////
// Chip register map and command bytes
////////////////////////////////////////////////////////////////////////////
`define RTC_ADDR_INIT      8'h00
`define RTC_ADDR_STAT      8'h01
`define RTC_INIT_BYTE      8'h10
`define RTC_TRANSF_CMD     8'hF0
`define RTC_STAT_AA_BIT    3     // Alarm off
`define RTC_STAT_FH_BIT    4     // Hour format

`define RTC_ADDR_DIA       8'h24
`define RTC_ADDR_MES       8'h25
`define RTC_ADDR_ANO       8'h26
`define RTC_ADDR_SEG       8'h21
`define RTC_ADDR_MIN       8'h22
`define RTC_ADDR_HORA      8'h23
`define RTC_ADDR_SEGCR     8'h41
`define RTC_ADDR_MINCR     8'h42
`define RTC_ADDR_HORACR    8'h43
`define RTC_NUM_TIME_REGS  9

// Scan index to chip address, same order as the time register enum
`define RTC_REG_ADDR(idx) \
    ((idx) == 4'd0 ? `RTC_ADDR_DIA   : \
     (idx) == 4'd1 ? `RTC_ADDR_MES   : \
     (idx) == 4'd2 ? `RTC_ADDR_ANO   : \
     (idx) == 4'd3 ? `RTC_ADDR_SEG   : \
     (idx) == 4'd4 ? `RTC_ADDR_MIN   : \
     (idx) == 4'd5 ? `RTC_ADDR_HORA  : \
     (idx) == 4'd6 ? `RTC_ADDR_SEGCR : \
     (idx) == 4'd7 ? `RTC_ADDR_MINCR : `RTC_ADDR_HORACR)

`endif

// File: src/rtc_bus_pkg.sv
`default_nettype none

package rtc_bus_pkg;

    // Address byte seen as page and register nibbles
    typedef struct packed {
        logic [3:0] page;
        logic [3:0] reg_n;
    } rtc_addr_s;

    typedef union packed {
        rtc_addr_s  addr;
        logic [7:0] data;
    } rtc_word_u;

    // Scan order of the reader, also the rd_index code
    typedef enum logic [3:0] {
        TR_DIA    = 4'd0,
        TR_MES    = 4'd1,
        TR_ANO    = 4'd2,
        TR_SEG    = 4'd3,
        TR_MIN    = 4'd4,
        TR_HORA   = 4'd5,
        TR_SEGCR  = 4'd6,
        TR_MINCR  = 4'd7,
        TR_HORACR = 4'd8
    } time_reg_e;

endpackage

`default_nettype wire

// File: src/rtc_mode_pkg.sv
`default_nettype none

package rtc_mode_pkg;

    typedef enum logic [1:0] {
        MODE_INIT   = 2'd0,
        MODE_READ   = 2'd1,
        MODE_WRITE  = 2'd2,
        MODE_STATUS = 2'd3
    } ctrl_mode_e;

endpackage

`default_nettype wire

// File: src/rtc_mode_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module rtc_mode_fsm (
    input  wire                      reloj,
    input  wire                      resetM,
    input  wire                      p_hora,
    input  wire                      p_fecha,
    input  wire                      p_crono,
    input  wire                      a_a,
    input  wire                      f_h,
    input  wire                      r_rtc,
    output rtc_mode_pkg::ctrl_mode_e mode
);

    logic [2:0] psi;    // {program, status, init}

    always_ff @(posedge reloj)
    begin
        if (resetM)
            psi <= 3'b001;      // Decodes to Init
        else
            psi <= {p_hora | p_fecha | p_crono, a_a | f_h, r_rtc};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Mode register with init over status and status over write
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge reloj)
    begin
        if (resetM)
            mode <= rtc_mode_pkg::MODE_INIT;
        else
        begin
            casez (psi)
                3'b??1:  mode <= rtc_mode_pkg::MODE_INIT;
                3'b?10:  mode <= rtc_mode_pkg::MODE_STATUS;
                3'b100:  mode <= rtc_mode_pkg::MODE_WRITE;
                3'b000:  mode <= rtc_mode_pkg::MODE_READ;
                default: mode <= rtc_mode_pkg::MODE_INIT;   // Unknown switch state
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/bus_cycle_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "rtc_cfg.svh"

module bus_cycle_gen (
    input  wire        reloj,
    input  wire        resetM,
    output logic       cycle_start,
    output logic [4:0] offset,
    output logic       cs_addr_win,
    output logic       cs_data_win,
    output logic       ad_win
);

    localparam logic [4:0] LAST = 5'(`RTC_CYCLE_LEN - 1);

    always_ff @(posedge reloj)
    begin
        if (resetM)
            offset <= 5'd0;
        else if (offset == LAST)
            offset <= 5'd0;
        else
            offset <= offset + 5'd1;
    end

    assign cycle_start = (offset == 5'd0);

    ////////////////////////////////////////////////////////////////////////////
    // Strobe windows, one clock behind the offset they decode
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            cs_addr_win <= 1'b0;
            cs_data_win <= 1'b0;
            ad_win      <= 1'b0;
        end
        else
        begin
            cs_addr_win <= (offset >= `RTC_CS1_LO) && (offset < `RTC_CS1_HI);
            cs_data_win <= (offset >= `RTC_CS2_LO) && (offset < `RTC_CS2_HI);
            ad_win      <= (offset >= `RTC_AD_LO)  && (offset < `RTC_AD_HI);
        end
    end

endmodule

`default_nettype wire

// File: src/rtc_bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "rtc_cfg.svh"

module rtc_bus_arbiter (
    input  wire                      reloj,
    input  wire                      resetM,
    input  wire rtc_mode_pkg::ctrl_mode_e mode,
    input  wire                      cycle_start,
    input  wire [4:0]                offset,
    input  wire                      cs_addr_win,
    input  wire                      cs_data_win,
    input  wire                      ad_win,
    input  wire rtc_bus_pkg::rtc_word_u writer_addr,
    input  wire rtc_bus_pkg::rtc_word_u writer_data,
    input  wire rtc_bus_pkg::rtc_word_u reader_addr,
    output logic                     writer_step,
    output logic                     reader_step,
    output logic                     cs_n,
    output logic                     rd_n,
    output logic                     wr_n,
    output logic                     ad_n,
    inout  wire  [7:0]               dir_dato
);

    localparam logic [4:0] LAST = 5'(`RTC_CYCLE_LEN - 1);

    logic                   reader_grant_q;
    logic                   reader_grant;    // Valid already at offset 0
    rtc_bus_pkg::rtc_word_u cur_addr;

    // Grant only moves on a cycle boundary
    always_ff @(posedge reloj)
    begin
        if (resetM)
            reader_grant_q <= 1'b0;
        else if (cycle_start)
            reader_grant_q <= (mode == rtc_mode_pkg::MODE_READ);
    end

    assign reader_grant = cycle_start ? (mode == rtc_mode_pkg::MODE_READ) : reader_grant_q;

    ////////////////////////////////////////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////////////////////////////////////////
    assign cs_n = ~(cs_addr_win | cs_data_win);
    assign rd_n = ~(cs_data_win & reader_grant_q);
    assign wr_n = ~(cs_addr_win | (cs_data_win & ~reader_grant_q));   // Latch addr, then data
    assign ad_n = ~ad_win;

    // Step pulses on the last clock of a held cycle
    assign writer_step = (offset == LAST) & ~reader_grant_q;
    assign reader_step = (offset == LAST) & reader_grant_q;

    ////////////////////////////////////////////////////////////////////////////
    // Tri-state bus driver
    ////////////////////////////////////////////////////////////////////////////
    assign cur_addr = reader_grant ? reader_addr : writer_addr;

    assign dir_dato = (offset < `RTC_AD_HI) ? cur_addr.data :
                      (!reader_grant_q)     ? writer_data.data :
                                              8'bzzzz_zzzz;     // Chip drives on reads

endmodule

`default_nettype wire

// File: src/time_writer.sv
`timescale 1ns/10ps
`default_nettype none

`include "rtc_cfg.svh"

module time_writer (
    input  wire                      reloj,
    input  wire                      resetM,
    input  wire rtc_mode_pkg::ctrl_mode_e mode,
    input  wire                      writer_step,
    input  wire                      a_a,
    input  wire                      f_h,
    input  wire  [7:0]               wr_dia,
    input  wire  [7:0]               wr_mes,
    input  wire  [7:0]               wr_ano,
    input  wire  [7:0]               wr_seg,
    input  wire  [7:0]               wr_min,
    input  wire  [7:0]               wr_hora,
    input  wire  [7:0]               wr_segcr,
    input  wire  [7:0]               wr_mincr,
    input  wire  [7:0]               wr_horacr,
    output rtc_bus_pkg::rtc_word_u   writer_addr,
    output rtc_bus_pkg::rtc_word_u   writer_data
);

    localparam logic [3:0] CMD_SLOT = 4'(`RTC_NUM_TIME_REGS);

    rtc_mode_pkg::ctrl_mode_e mode_q;
    logic [3:0]               slot_q;
    logic [3:0]               slot_nx;
    logic [7:0]               wr_byte_q;     // Time byte of the current slot
    logic [7:0]               stat_byte;

    // Only Write mode has more than one slot
    always_comb
    begin
        slot_nx = slot_q;
        if (mode != mode_q)
            slot_nx = 4'd0;
        else if (writer_step)
            slot_nx = (mode == rtc_mode_pkg::MODE_WRITE && slot_q < CMD_SLOT) ?
                      slot_q + 4'd1 : 4'd0;
    end

    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            mode_q <= rtc_mode_pkg::MODE_INIT;
            slot_q <= 4'd0;
        end
        else
        begin
            mode_q <= mode;
            slot_q <= slot_nx;
        end
    end

    // Inputs sampled at the slot start
    always_ff @(posedge reloj)
    begin
        if (writer_step || mode != mode_q)
        begin
            case (slot_nx)
                4'd0:    wr_byte_q <= wr_dia;
                4'd1:    wr_byte_q <= wr_mes;
                4'd2:    wr_byte_q <= wr_ano;
                4'd3:    wr_byte_q <= wr_seg;
                4'd4:    wr_byte_q <= wr_min;
                4'd5:    wr_byte_q <= wr_hora;
                4'd6:    wr_byte_q <= wr_segcr;
                4'd7:    wr_byte_q <= wr_mincr;
                4'd8:    wr_byte_q <= wr_horacr;
                default: wr_byte_q <= 8'h00;
            endcase
        end
    end

    always_comb
    begin
        stat_byte                   = 8'h00;
        stat_byte[`RTC_STAT_AA_BIT] = a_a;
        stat_byte[`RTC_STAT_FH_BIT] = f_h;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address and data of the current slot
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        writer_addr.data = `RTC_ADDR_INIT;
        writer_data.data = `RTC_INIT_BYTE;
        case (mode)
            rtc_mode_pkg::MODE_STATUS:
            begin
                writer_addr.data = `RTC_ADDR_STAT;
                writer_data.data = stat_byte;
            end
            rtc_mode_pkg::MODE_WRITE:
            begin
                if (slot_q == CMD_SLOT)
                begin
                    writer_addr.data = `RTC_TRANSF_CMD;     // Copy buffer into clock
                    writer_data.data = 8'h00;
                end
                else
                begin
                    writer_addr.data = `RTC_REG_ADDR(slot_q);
                    writer_data.data = wr_byte_q;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/time_reader.sv
`timescale 1ns/10ps
`default_nettype none

`include "rtc_cfg.svh"

module time_reader (
    input  wire                     reloj,
    input  wire                     resetM,
    input  wire                     reader_step,
    input  wire  [4:0]              offset,
    input  wire  [7:0]              dir_dato,
    output rtc_bus_pkg::rtc_word_u  reader_addr,
    output logic [7:0]              rd_dia,
    output logic [7:0]              rd_mes,
    output logic [7:0]              rd_ano,
    output logic [7:0]              rd_seg,
    output logic [7:0]              rd_min,
    output logic [7:0]              rd_hora,
    output logic [7:0]              rd_segcr,
    output logic [7:0]              rd_mincr,
    output logic [7:0]              rd_horacr,
    output logic                    rd_strobe,
    output rtc_bus_pkg::time_reg_e  rd_index
);

    localparam logic [4:0] CAPTURE_OFS = 5'(`RTC_CS2_HI - 1);   // Last clock of rd_n low

    rtc_bus_pkg::time_reg_e slot_q;
    logic [7:0]             map_addr;
    logic [7:0]             cap_byte;

    assign map_addr = `RTC_REG_ADDR(slot_q);

    // Page nibble picks the clock or chrono bank
    always_comb
    begin
        reader_addr.addr.page  = map_addr[7:4];
        reader_addr.addr.reg_n = map_addr[3:0];
    end

    always_ff @(posedge reloj)
    begin
        if (offset == CAPTURE_OFS)
            cap_byte <= dir_dato;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scan and demux, committed only when the cycle was ours
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge reloj)
    begin
        if (resetM)
        begin
            slot_q    <= rtc_bus_pkg::TR_DIA;
            rd_index  <= rtc_bus_pkg::TR_DIA;
            rd_strobe <= 1'b0;
            rd_dia    <= 8'h00;
            rd_mes    <= 8'h00;
            rd_ano    <= 8'h00;
            rd_seg    <= 8'h00;
            rd_min    <= 8'h00;
            rd_hora   <= 8'h00;
            rd_segcr  <= 8'h00;
            rd_mincr  <= 8'h00;
            rd_horacr <= 8'h00;
        end
        else
        begin
            rd_strobe <= reader_step;
            if (reader_step)
            begin
                rd_index <= slot_q;
                case (slot_q)
                    rtc_bus_pkg::TR_DIA:   rd_dia    <= cap_byte;
                    rtc_bus_pkg::TR_MES:   rd_mes    <= cap_byte;
                    rtc_bus_pkg::TR_ANO:   rd_ano    <= cap_byte;
                    rtc_bus_pkg::TR_SEG:   rd_seg    <= cap_byte;
                    rtc_bus_pkg::TR_MIN:   rd_min    <= cap_byte;
                    rtc_bus_pkg::TR_HORA:  rd_hora   <= cap_byte;
                    rtc_bus_pkg::TR_SEGCR: rd_segcr  <= cap_byte;
                    rtc_bus_pkg::TR_MINCR: rd_mincr  <= cap_byte;
                    default:               rd_horacr <= cap_byte;
                endcase
                if (slot_q == rtc_bus_pkg::TR_HORACR)
                    slot_q <= rtc_bus_pkg::TR_DIA;
                else
                    slot_q <= rtc_bus_pkg::time_reg_e'(slot_q + 4'd1);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rtc_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module rtc_ctrl_top (
    input  wire                      reloj,
    input  wire                      resetM,
    input  wire                      p_hora,
    input  wire                      p_fecha,
    input  wire                      p_crono,
    input  wire                      a_a,
    input  wire                      f_h,
    input  wire                      r_rtc,
    input  wire  [7:0]               wr_dia,
    input  wire  [7:0]               wr_mes,
    input  wire  [7:0]               wr_ano,
    input  wire  [7:0]               wr_seg,
    input  wire  [7:0]               wr_min,
    input  wire  [7:0]               wr_hora,
    input  wire  [7:0]               wr_segcr,
    input  wire  [7:0]               wr_mincr,
    input  wire  [7:0]               wr_horacr,
    output logic                     cs_n,
    output logic                     rd_n,
    output logic                     wr_n,
    output logic                     ad_n,
    output rtc_mode_pkg::ctrl_mode_e mode,
    output logic [7:0]               rd_dia,
    output logic [7:0]               rd_mes,
    output logic [7:0]               rd_ano,
    output logic [7:0]               rd_seg,
    output logic [7:0]               rd_min,
    output logic [7:0]               rd_hora,
    output logic [7:0]               rd_segcr,
    output logic [7:0]               rd_mincr,
    output logic [7:0]               rd_horacr,
    output logic                     rd_strobe,
    output rtc_bus_pkg::time_reg_e   rd_index,
    inout  wire  [7:0]               dir_dato
);

    logic                   cycle_start;
    logic [4:0]             offset;
    logic                   cs_addr_win;
    logic                   cs_data_win;
    logic                   ad_win;
    logic                   writer_step;
    logic                   reader_step;
    rtc_bus_pkg::rtc_word_u writer_addr;
    rtc_bus_pkg::rtc_word_u writer_data;
    rtc_bus_pkg::rtc_word_u reader_addr;

    rtc_mode_fsm u_mode (
        .reloj(reloj), .resetM(resetM),
        .p_hora(p_hora), .p_fecha(p_fecha), .p_crono(p_crono),
        .a_a(a_a), .f_h(f_h), .r_rtc(r_rtc),
        .mode(mode)
    );

    bus_cycle_gen u_cycle (
        .reloj(reloj), .resetM(resetM),
        .cycle_start(cycle_start), .offset(offset),
        .cs_addr_win(cs_addr_win), .cs_data_win(cs_data_win), .ad_win(ad_win)
    );

    rtc_bus_arbiter u_arb (
        .reloj(reloj), .resetM(resetM), .mode(mode),
        .cycle_start(cycle_start), .offset(offset),
        .cs_addr_win(cs_addr_win), .cs_data_win(cs_data_win), .ad_win(ad_win),
        .writer_addr(writer_addr), .writer_data(writer_data), .reader_addr(reader_addr),
        .writer_step(writer_step), .reader_step(reader_step),
        .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n), .ad_n(ad_n),
        .dir_dato(dir_dato)
    );

    time_writer u_writer (
        .reloj(reloj), .resetM(resetM), .mode(mode), .writer_step(writer_step),
        .a_a(a_a), .f_h(f_h),
        .wr_dia(wr_dia), .wr_mes(wr_mes), .wr_ano(wr_ano),
        .wr_seg(wr_seg), .wr_min(wr_min), .wr_hora(wr_hora),
        .wr_segcr(wr_segcr), .wr_mincr(wr_mincr), .wr_horacr(wr_horacr),
        .writer_addr(writer_addr), .writer_data(writer_data)
    );

    time_reader u_reader (
        .reloj(reloj), .resetM(resetM), .reader_step(reader_step),
        .offset(offset), .dir_dato(dir_dato), .reader_addr(reader_addr),
        .rd_dia(rd_dia), .rd_mes(rd_mes), .rd_ano(rd_ano),
        .rd_seg(rd_seg), .rd_min(rd_min), .rd_hora(rd_hora),
        .rd_segcr(rd_segcr), .rd_mincr(rd_mincr), .rd_horacr(rd_horacr),
        .rd_strobe(rd_strobe), .rd_index(rd_index)
    );

endmodule

`default_nettype wire

// File: sim/rtc_chip_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "rtc_cfg.svh"

module rtc_chip_model (
    input  wire       cs_n,
    input  wire       rd_n,
    input  wire       wr_n,
    input  wire       ad_n,
    inout  wire [7:0] dir_dato
);

    logic [7:0]  mem [0:255];
    logic [7:0]  addr;              // Register address latched in the address phase
    logic        wr_last;
    int unsigned data_writes;
    int unsigned transf_count;      // Transfer commands seen as an address

    initial
    begin
        for (int a = 0; a < 256; a++)
            mem[a] = 8'(a) ^ 8'hA5;
        addr         = 8'h00;
        wr_last      = 1'b1;
        data_writes  = 0;
        transf_count = 0;
    end

    // Rising edge of wr_n, address while ad_n is low and data otherwise
    always @(wr_n)
    begin
        if (wr_last === 1'b0 && wr_n === 1'b1)
        begin
            if (ad_n === 1'b0)
            begin
                addr = dir_dato;
                if (dir_dato == `RTC_TRANSF_CMD)
                    transf_count++;
            end
            else
            begin
                mem[addr] = dir_dato;
                data_writes++;
            end
        end
        wr_last = wr_n;
    end

    assign dir_dato = (!rd_n && !cs_n) ? mem[addr] : 8'bzzzz_zzzz;

endmodule

`default_nettype wire

// File: sim/rtc_ctrl_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "rtc_cfg.svh"

module rtc_ctrl_chk (
    input  wire       reloj,
    input  wire       resetM,
    input  wire       cs_n,
    input  wire       rd_n,
    input  wire       wr_n,
    input  wire       ad_n,
    input  wire [1:0] mode,
    input  wire [4:0] offset
);

    int unsigned fail_count;

    initial
        fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////////////////////////////////////////
    a_reset_idle: assert property (@(posedge reloj)
        resetM |=> (cs_n && rd_n && wr_n && ad_n && mode == rtc_mode_pkg::MODE_INIT))
    else
    begin
        $error("strobes not idle or mode not Init after a reset clock");
        fail_count++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobe windows
    ////////////////////////////////////////////////////////////////////////////
    a_rd_wr_apart: assert property (@(posedge reloj) disable iff (resetM)
        (rd_n || wr_n))
    else
    begin
        $error("rd_n and wr_n low together");
        fail_count++;
    end

    // Registered windows run one offset late
    a_wr_in_select: assert property (@(posedge reloj) disable iff (resetM)
        !wr_n |-> (!cs_n && ((offset > `RTC_CS1_LO && offset <= `RTC_CS1_HI) ||
                             (offset > `RTC_CS2_LO && offset <= `RTC_CS2_HI))))
    else
    begin
        $error("wr_n low outside a chip select window");
        fail_count++;
    end

    a_ad_addr_phase: assert property (@(posedge reloj) disable iff (resetM)
        !ad_n |-> (offset > `RTC_AD_LO && offset <= `RTC_AD_HI))
    else
    begin
        $error("ad_n low outside the address phase");
        fail_count++;
    end

    a_rd_data_phase: assert property (@(posedge reloj) disable iff (resetM)
        !rd_n |-> (offset > `RTC_CS2_LO && offset <= `RTC_CS2_HI))
    else
    begin
        $error("rd_n low outside the data strobe window");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: sim/rtc_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rtc_cfg.svh"

module rtc_ctrl_tb;

    localparam int CLK_HALF       = 50;
    localparam int CLK_PERIOD     = 2 * CLK_HALF;
    localparam int BUS_CLOCKS     = `RTC_CYCLE_LEN;
    localparam int INIT_CYCLES    = 3;
    localparam int READ_CYCLES    = 24;
    localparam int WRITE_CYCLES   = 14;
    localparam int STATUS_CYCLES  = 3;      // Per combination of a_a and f_h
    localparam int PLANNED_CYCLES = INIT_CYCLES + READ_CYCLES + WRITE_CYCLES +
                                    3 * STATUS_CYCLES;
    localparam int WATCHDOG_NS    = (PLANNED_CYCLES + 4) * BUS_CLOCKS * CLK_PERIOD;
    localparam int WAIT_WRITES    = 0;
    localparam int WAIT_STROBES   = 1;
    localparam int WAIT_TRANSFER  = 2;

    logic                     reloj;
    logic                     resetM;
    logic                     p_hora;
    logic                     p_fecha;
    logic                     p_crono;
    logic                     a_a;
    logic                     f_h;
    logic                     r_rtc;
    logic [7:0]               wr_val [0:8];     // Scan order with dia first
    wire  [7:0]               rd_val [0:8];
    wire                      cs_n;
    wire                      rd_n;
    wire                      wr_n;
    wire                      ad_n;
    wire                      rd_strobe;
    wire  [7:0]               dir_dato;
    rtc_mode_pkg::ctrl_mode_e mode;
    rtc_bus_pkg::time_reg_e   rd_index;

    logic [31:0] lcg_state;
    logic [7:0]  rnd;
    logic [7:0]  rd_exp [0:8];
    logic [3:0]  exp_index    = 4'd0;
    logic [1:0]  combo;
    int unsigned errors       = 0;
    int unsigned checks       = 0;
    int unsigned strobe_count = 0;
    int unsigned err_mark;

    rtc_ctrl_top uut (
        .reloj(reloj), .resetM(resetM),
        .p_hora(p_hora), .p_fecha(p_fecha), .p_crono(p_crono),
        .a_a(a_a), .f_h(f_h), .r_rtc(r_rtc),
        .wr_dia(wr_val[0]), .wr_mes(wr_val[1]), .wr_ano(wr_val[2]),
        .wr_seg(wr_val[3]), .wr_min(wr_val[4]), .wr_hora(wr_val[5]),
        .wr_segcr(wr_val[6]), .wr_mincr(wr_val[7]), .wr_horacr(wr_val[8]),
        .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n), .ad_n(ad_n), .mode(mode),
        .rd_dia(rd_val[0]), .rd_mes(rd_val[1]), .rd_ano(rd_val[2]),
        .rd_seg(rd_val[3]), .rd_min(rd_val[4]), .rd_hora(rd_val[5]),
        .rd_segcr(rd_val[6]), .rd_mincr(rd_val[7]), .rd_horacr(rd_val[8]),
        .rd_strobe(rd_strobe), .rd_index(rd_index),
        .dir_dato(dir_dato)
    );

    rtc_chip_model model (
        .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n), .ad_n(ad_n), .dir_dato(dir_dato)
    );

    bind rtc_ctrl_top rtc_ctrl_chk u_chk (
        .reloj(reloj), .resetM(resetM),
        .cs_n(cs_n), .rd_n(rd_n), .wr_n(wr_n), .ad_n(ad_n),
        .mode(mode), .offset(offset)
    );

    initial
    begin
        reloj = 1'b0;
        forever
            #CLK_HALF reloj = ~reloj;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] chip_addr(input logic [3:0] idx);
        case (idx)
            4'd0:    return `RTC_ADDR_DIA;
            4'd1:    return `RTC_ADDR_MES;
            4'd2:    return `RTC_ADDR_ANO;
            4'd3:    return `RTC_ADDR_SEG;
            4'd4:    return `RTC_ADDR_MIN;
            4'd5:    return `RTC_ADDR_HORA;
            4'd6:    return `RTC_ADDR_SEGCR;
            4'd7:    return `RTC_ADDR_MINCR;
            default: return `RTC_ADDR_HORACR;
        endcase
    endfunction

    // Alarm off and hour format bits over a zero byte
    function automatic logic [7:0] expected_status(input logic alarm_off, input logic hour_fmt);
        logic [7:0] s;
        s                   = 8'h00;
        s[`RTC_STAT_AA_BIT] = alarm_off;
        s[`RTC_STAT_FH_BIT] = hour_fmt;
        return s;
    endfunction

    function automatic string reg_name(input logic [3:0] idx);
        case (idx)
            4'd0:    return "rd_dia";
            4'd1:    return "rd_mes";
            4'd2:    return "rd_ano";
            4'd3:    return "rd_seg";
            4'd4:    return "rd_min";
            4'd5:    return "rd_hora";
            4'd6:    return "rd_segcr";
            4'd7:    return "rd_mincr";
            default: return "rd_horacr";
        endcase
    endfunction

    function automatic int unsigned progress(input int sel);
        case (sel)
            WAIT_WRITES:  return model.data_writes;
            WAIT_STROBES: return strobe_count;
            default:      return model.transf_count;
        endcase
    endfunction

    task automatic next_rand_byte(output logic [7:0] b);
        lcg_state = lcg_next(lcg_state);
        b         = lcg_state[23:16];
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %02h, got %02h", $time, name, exp, got);
        end
    endtask

    // Returns 5 ns after a rising edge so the next stimulus can follow
    task automatic wait_progress(input int sel, input int unsigned count,
                                 input int max_cycles, input string what);
        int unsigned start;
        int          clocks;
        start  = progress(sel);
        clocks = 0;
        while (progress(sel) - start < count && clocks < max_cycles * BUS_CLOCKS)
        begin
            @(posedge reloj);
            #5;
            clocks++;
        end
        if (progress(sel) - start < count)
        begin
            errors++;
            $display("Timeout after %0d bus cycles waiting for %s", max_cycles, what);
        end
    endtask

    task automatic report_test(input string name, input int unsigned mark);
        if (errors == mark)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d error(s)", name, errors - mark);
    endtask

    // Each read strobe against the chip model and the scan order
    always @(negedge reloj)
    begin
        if (rd_strobe === 1'b1)
        begin
            check_value("rd_index", {4'h0, rd_index}, {4'h0, exp_index});
            check_value(reg_name(exp_index), rd_val[exp_index],
                        model.mem[chip_addr(exp_index)]);
            exp_index = (exp_index == 4'd8) ? 4'd0 : exp_index + 4'd1;
            strobe_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        lcg_state = 32'h1f35a36e;
        resetM    = 1'b1;
        r_rtc     = 1'b1;       // Stay in Init once out of reset
        p_hora    = 1'b0;
        p_fecha   = 1'b0;
        p_crono   = 1'b0;
        a_a       = 1'b0;
        f_h       = 1'b0;
        for (int i = 0; i < `RTC_NUM_TIME_REGS; i++)
            wr_val[i] = 8'h00;
        repeat (10) @(posedge reloj);
        #5;

        err_mark = errors;
        check_value("cs_n", {7'b0, cs_n}, 8'h01);
        check_value("rd_n", {7'b0, rd_n}, 8'h01);
        check_value("wr_n", {7'b0, wr_n}, 8'h01);
        check_value("ad_n", {7'b0, ad_n}, 8'h01);
        check_value("mode", {6'b0, mode}, {6'b0, rtc_mode_pkg::MODE_INIT});
        resetM = 1'b0;
        report_test("1 reset state", err_mark);

        err_mark = errors;
        wait_progress(WAIT_WRITES, 1, INIT_CYCLES, "the init register write");
        check_value("chip init register", model.mem[`RTC_ADDR_INIT], `RTC_INIT_BYTE);
        report_test("2 init", err_mark);

        err_mark = errors;
        for (int i = 0; i < `RTC_NUM_TIME_REGS; i++)
        begin
            next_rand_byte(rnd);
            model.mem[chip_addr(4'(i))] = rnd;
            rd_exp[i]                   = rnd;
        end
        r_rtc = 1'b0;
        wait_progress(WAIT_STROBES, 2 * `RTC_NUM_TIME_REGS, READ_CYCLES, "two read scans");
        for (int i = 0; i < `RTC_NUM_TIME_REGS; i++)
            check_value(reg_name(4'(i)), rd_val[i], rd_exp[i]);
        report_test("3 read scan", err_mark);

        err_mark = errors;
        for (int i = 0; i < `RTC_NUM_TIME_REGS; i++)
        begin
            next_rand_byte(rnd);
            wr_val[i] = rnd;
        end
        p_hora = 1'b1;
        wait_progress(WAIT_TRANSFER, 1, WRITE_CYCLES, "the transfer command");
        for (int i = 0; i < `RTC_NUM_TIME_REGS; i++)
            check_value($sformatf("chip register %02h", chip_addr(4'(i))),
                        model.mem[chip_addr(4'(i))], wr_val[i]);
        report_test("4 write", err_mark);

        // Combinations 01, 10, 11, then 00 which leaves Status
        err_mark = errors;
        p_hora   = 1'b0;
        for (int c = 0; c < 4; c++)
        begin
            combo = 2'(c + 1);
            a_a   = combo[0];
            f_h   = combo[1];
            repeat (2) @(posedge reloj);
            #5;
            if (combo != 2'b00)
            begin
                check_value("mode", {6'b0, mode}, {6'b0, rtc_mode_pkg::MODE_STATUS});
                wait_progress(WAIT_WRITES, 2, STATUS_CYCLES, "the status register writes");
                check_value("chip status register", model.mem[`RTC_ADDR_STAT],
                            expected_status(combo[0], combo[1]));
            end
            else
                check_value("mode", {6'b0, mode}, {6'b0, rtc_mode_pkg::MODE_READ});
        end
        report_test("5 status", err_mark);

        repeat (2) @(posedge reloj);
        #5;
        $display("Checks: %0d run, %0d mismatched, %0d assertion failures",
                 checks, errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
src/rtc_bus_pkg.sv
src/rtc_mode_pkg.sv
src/rtc_mode_fsm.sv
src/bus_cycle_gen.sv
src/rtc_bus_arbiter.sv
src/time_writer.sv
src/time_reader.sv
src/rtc_ctrl_top.sv
sim/rtc_chip_model.sv
sim/rtc_ctrl_chk.sv
sim/rtc_ctrl_tb.sv
